//--- hdl/mips_isa_pkg.sv
// Only the opcodes and funct codes listed here are decoded; shamt is ignored and no traps exist
package mips_isa_pkg;

    localparam int opcode_w = 6;            // Instruction field widths
    localparam int reg_w    = 5;
    localparam int funct_w  = 6;
    localparam int imm_w    = 16;
    localparam int target_w = 26;

    typedef enum logic [opcode_w-1:0] {
        op_rtype = 6'h00,                   // Operation chosen by funct
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_addiu = 6'h09,
        op_andi  = 6'h0c,                   // Zero-extended immediate
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } op_t;

    typedef enum logic [funct_w-1:0] {
        funct_addu = 6'h21,
        funct_subu = 6'h23,
        funct_and  = 6'h24,
        funct_or   = 6'h25,
        funct_slt  = 6'h2a                  // Signed compare
    } funct_t;

    typedef logic [reg_w-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        srcb_reg,                           // B register
        srcb_four,                          // PC increment
        srcb_imm,                           // Extended immediate
        srcb_imm4                           // Branch offset in bytes
    } srcb_t;

    typedef enum logic [1:0] {
        pc_alu,                             // PC + 4 straight from the ALU
        pc_aluout,                          // Branch target held in ALUOut
        pc_jump                             // Upper PC bits with the J target
    } pc_src_t;

    typedef struct packed {
        op_t                 opcode;
        reg_idx_t            rs;
        reg_idx_t            rt;
        reg_idx_t            rd;
        funct_t              funct;
        logic [imm_w-1:0]    imm;
        logic [target_w-1:0] target;
    } instr_fields_t;

    typedef struct packed {
        logic    pc_en;
        logic    ir_en;
        logic    mdr_en;
        logic    ab_en;                     // Loads A and B together
        logic    aluout_en;
        logic    reg_write;
        logic    reg_dst;                   // 1 writes rd, 0 writes rt
        logic    mem_to_reg;                // 1 writes MDR, 0 writes ALUOut
        logic    alu_src_a;                 // 1 takes A, 0 takes PC
        srcb_t   alu_src_b;
        alu_op_t alu_op;
        pc_src_t pc_src;
        logic    iord;                      // 1 addresses data through ALUOut
        logic    bus_req;
        logic    bus_write;
    } ctrl_t;

endpackage

//--- hdl/mips_bus_pkg.sv
// Flat byte address map with memory from zero and GPIO from 0x800; accesses are whole words only
package mips_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [7:0]  gpio_t;

    localparam int mem_words = 256;                     // Memory depth in words
    typedef logic [$clog2(mem_words)-1:0] mem_index_t;

    localparam addr_t boot_addr    = 32'h0000_0000;     // First fetch address
    localparam addr_t gpio_base    = 32'h0000_0800;
    localparam addr_t gpio_out_ofs = 32'h0000_0000;     // Output byte, write strobes
    localparam addr_t gpio_in_ofs  = 32'h0000_0004;     // Input byte, read only

    localparam string mem_file = "sim/prog.hex";        // Relative to the run directory

endpackage

//--- hdl/apb_if.sv
// One APB segment with no pslverr and no pprot; the decoder modport is purely combinational
`timescale 1ns/100ps

interface apb_if
    import mips_bus_pkg::*;
(
    input logic pclk
);
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pready;

    modport master (
        input  pclk, prdata, pready,
        output psel, penable, pwrite, paddr, pwdata
    );

    modport slave (
        input  pclk, psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

    modport decoder (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready
    );

endinterface

//--- hdl/mips_control.sv
// Multicycle sequencer; unknown opcodes are skipped and each bus phase waits on bus_done
`timescale 1ns/100ps

module mips_control
    import mips_isa_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  instr_fields_t fields,
    input  logic          zero,
    input  logic          bus_done,
    output ctrl_t         ctrl
);
    typedef enum logic [3:0] {
        s_boot,                             // One idle cycle out of reset
        s_fetch_setup,
        s_fetch_access,
        s_decode,
        s_execute,
        s_mem_setup,
        s_mem_access,
        s_writeback,
        s_branch
    } state_t;

    state_t state;
    state_t state_next;
    logic   is_mem;                         // lw or sw in IR

    function automatic alu_op_t funct_alu(funct_t f);
        case (f)
            funct_subu: return alu_sub;
            funct_and:  return alu_and;
            funct_or:   return alu_or;
            funct_slt:  return alu_slt;
            default:    return alu_add;     // addu and anything unsupported
        endcase
    endfunction

    assign is_mem = (fields.opcode == op_lw) || (fields.opcode == op_sw);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_boot;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_boot:         state_next = s_fetch_setup;
            s_fetch_setup:  state_next = s_fetch_access;
            s_fetch_access: if (bus_done) state_next = s_decode;
            s_decode: begin
                case (fields.opcode)
                    op_rtype, op_addiu, op_andi, op_lw, op_sw: state_next = s_execute;
                    op_beq, op_j: state_next = s_branch;
                    default:      state_next = s_fetch_setup;
                endcase
            end
            s_execute:      state_next = is_mem ? s_mem_setup : s_writeback;
            s_mem_setup:    state_next = s_mem_access;
            s_mem_access: begin
                if (bus_done) begin
                    state_next = (fields.opcode == op_lw) ? s_writeback : s_fetch_setup;
                end
            end
            s_writeback, s_branch: state_next = s_fetch_setup;
            default:        state_next = s_boot;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.alu_src_b = srcb_four;         // Default ALU use is PC + 4
        ctrl.alu_op    = alu_add;
        ctrl.pc_src    = pc_alu;
        case (state)
            s_fetch_setup: ctrl.bus_req = 1'b1;
            s_fetch_access: begin
                ctrl.bus_req = 1'b1;
                ctrl.ir_en   = bus_done;    // Latch instruction and step PC together
                ctrl.pc_en   = bus_done;
            end
            s_decode: begin
                ctrl.ab_en     = 1'b1;
                ctrl.aluout_en = 1'b1;      // Branch target from PC + 4
                ctrl.alu_src_b = srcb_imm4;
            end
            s_execute: begin
                ctrl.alu_src_a = 1'b1;
                ctrl.aluout_en = 1'b1;
                if (fields.opcode == op_rtype) begin
                    ctrl.alu_src_b = srcb_reg;
                    ctrl.alu_op    = funct_alu(fields.funct);
                end else begin
                    ctrl.alu_src_b = srcb_imm;      // Address or immediate operand
                    if (fields.opcode == op_andi) begin
                        ctrl.alu_op = alu_and;
                    end
                end
            end
            s_mem_setup, s_mem_access: begin
                ctrl.bus_req   = 1'b1;
                ctrl.iord      = 1'b1;
                ctrl.bus_write = (fields.opcode == op_sw);
                ctrl.mdr_en    = (state == s_mem_access) && bus_done;
            end
            s_writeback: begin
                ctrl.reg_write  = 1'b1;
                ctrl.reg_dst    = (fields.opcode == op_rtype);
                ctrl.mem_to_reg = (fields.opcode == op_lw);
            end
            s_branch: begin
                ctrl.alu_src_a = 1'b1;      // A - B sets zero for beq
                ctrl.alu_src_b = srcb_reg;
                ctrl.alu_op    = alu_sub;
                if (fields.opcode == op_j) begin
                    ctrl.pc_src = pc_jump;
                    ctrl.pc_en  = 1'b1;
                end else begin
                    ctrl.pc_src = pc_aluout;
                    ctrl.pc_en  = zero;
                end
            end
            default: ctrl.bus_req = 1'b0;   // Boot cycle stays off the bus
        endcase
    end

endmodule

//--- hdl/mips_datapath.sv
// Datapath registers and the APB master phases; psel follows bus_req in the same cycle
`timescale 1ns/100ps

module mips_datapath
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  ctrl_t         ctrl,
    output instr_fields_t fields,
    output logic          zero,
    output logic          bus_done,
    apb_if.master         bus
);
    word_t    pc;
    word_t    ir;
    word_t    mdr;
    word_t    a_q;
    word_t    b_q;
    word_t    alu_out;
    word_t    regs [32];                    // Register file, entry 0 never written
    word_t    rd1;
    word_t    rd2;
    word_t    imm_ext;
    word_t    src_a;
    word_t    src_b;
    word_t    alu_res;
    word_t    jump_addr;
    word_t    pc_next;
    word_t    wd3;
    reg_idx_t wr_idx;
    logic     penable_q;

    assign fields.opcode = op_t'(ir[31:26]);
    assign fields.rs     = ir[25:21];
    assign fields.rt     = ir[20:16];
    assign fields.rd     = ir[15:11];
    assign fields.funct  = funct_t'(ir[5:0]);
    assign fields.imm    = ir[15:0];
    assign fields.target = ir[25:0];

    // $zero reads as zero whatever the array holds
    assign rd1 = (fields.rs == '0) ? '0 : regs[fields.rs];
    assign rd2 = (fields.rt == '0) ? '0 : regs[fields.rt];

    assign wr_idx = ctrl.reg_dst ? fields.rd : fields.rt;
    assign wd3    = ctrl.mem_to_reg ? mdr : alu_out;

    assign imm_ext = (fields.opcode == op_andi) ? {16'h0000, fields.imm}
                                                : {{16{fields.imm[15]}}, fields.imm};
    assign jump_addr = {pc[31:28], fields.target, 2'b00};

    assign src_a = ctrl.alu_src_a ? a_q : pc;

    always_comb begin
        case (ctrl.alu_src_b)
            srcb_reg:  src_b = b_q;
            srcb_four: src_b = 32'd4;
            srcb_imm:  src_b = imm_ext;
            default:   src_b = {imm_ext[29:0], 2'b00};   // Word offset to bytes
        endcase
    end

    always_comb begin
        case (ctrl.alu_op)
            alu_sub: alu_res = src_a - src_b;
            alu_and: alu_res = src_a & src_b;
            alu_or:  alu_res = src_a | src_b;
            alu_slt: alu_res = word_t'($signed(src_a) < $signed(src_b));
            default: alu_res = src_a + src_b;
        endcase
    end

    assign zero = (alu_res == '0);

    always_comb begin
        case (ctrl.pc_src)
            pc_aluout: pc_next = alu_out;
            pc_jump:   pc_next = jump_addr;
            default:   pc_next = alu_res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= boot_addr;
        end else if (ctrl.pc_en) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_en) begin
            ir <= bus.prdata;
        end
        if (ctrl.mdr_en) begin
            mdr <= bus.prdata;
        end
        if (ctrl.ab_en) begin
            a_q <= rd1;
            b_q <= rd2;
        end
        if (ctrl.aluout_en) begin
            alu_out <= alu_res;
        end
        if (ctrl.reg_write && (wr_idx != '0)) begin
            regs[wr_idx] <= wd3;
        end
    end

    // Setup while penable is low, access until pready
    always_ff @(posedge clk) begin
        if (reset) begin
            penable_q <= 1'b0;
        end else begin
            penable_q <= bus.psel & ~bus_done;
        end
    end

    assign bus_done    = penable_q & bus.pready;
    assign bus.psel    = ctrl.bus_req;
    assign bus.penable = penable_q;
    assign bus.pwrite  = ctrl.bus_write;
    assign bus.paddr   = ctrl.iord ? alu_out : pc;   // Held still by the FSM while selected
    assign bus.pwdata  = b_q;

endmodule

//--- hdl/apb_decoder.sv
// Address decode only; unmapped transfers finish at once with zero data and no side effect
`timescale 1ns/100ps

module apb_decoder
    import mips_bus_pkg::*;
(
    apb_if.decoder up,
    apb_if.master  mem,
    apb_if.master  gpio
);
    logic sel_mem;
    logic sel_gpio;

    assign sel_mem  = (up.paddr < addr_t'(mem_words * 4));
    assign sel_gpio = (up.paddr >= gpio_base);

    assign mem.psel    = up.psel & sel_mem;
    assign mem.penable = up.penable;
    assign mem.pwrite  = up.pwrite;
    assign mem.paddr   = up.paddr;
    assign mem.pwdata  = up.pwdata;

    assign gpio.psel    = up.psel & sel_gpio;
    assign gpio.penable = up.penable;
    assign gpio.pwrite  = up.pwrite;
    assign gpio.paddr   = up.paddr;
    assign gpio.pwdata  = up.pwdata;

    assign up.prdata = sel_mem ? mem.prdata : (sel_gpio ? gpio.prdata : '0);
    assign up.pready = sel_mem ? mem.pready : (sel_gpio ? gpio.pready : 1'b1);

endmodule

//--- hdl/mips_mem.sv
// Zero wait state word RAM preloaded from mem_file; byte address bits 1:0 are ignored
`timescale 1ns/100ps

module mips_mem
    import mips_bus_pkg::*;
(
    input logic  clk,
    apb_if.slave bus
);
    word_t      mem [mem_words];
    mem_index_t idx;

    initial $readmemh(mem_file, mem);       // Program and data image

    assign idx        = bus.paddr[$bits(mem_index_t)+1:2];
    assign bus.prdata = mem[idx];           // Valid in the access cycle
    assign bus.pready = 1'b1;

    always_ff @(posedge clk) begin
        if (bus.psel && bus.penable && bus.pwrite) begin
            mem[idx] <= bus.pwdata;
        end
    end

endmodule

//--- hdl/gpio_port.sv
// Zero wait state GPIO; only the low byte of a write is kept and other offsets read zero
`timescale 1ns/100ps

module gpio_port
    import mips_bus_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    apb_if.slave  bus,
    input  gpio_t gpio_data_in,
    output gpio_t gpio_data_out,
    output logic  gpio_strobe
);
    addr_t ofs;
    logic  wr_out;                          // Access cycle of a write to the output byte

    assign ofs    = bus.paddr - gpio_base;
    assign wr_out = bus.psel & bus.penable & bus.pwrite & (ofs == gpio_out_ofs);

    always_ff @(posedge clk) begin
        if (reset) begin
            gpio_data_out <= '0;
            gpio_strobe   <= 1'b0;
        end else begin
            gpio_strobe <= wr_out;          // One pulse, aligned with the new byte
            if (wr_out) begin
                gpio_data_out <= gpio_t'(bus.pwdata);
            end
        end
    end

    always_comb begin
        case (ofs)
            gpio_in_ofs:  bus.prdata = word_t'(gpio_data_in);
            gpio_out_ofs: bus.prdata = word_t'(gpio_data_out);  // Readback
            default:      bus.prdata = '0;
        endcase
    end

    assign bus.pready = 1'b1;

endmodule

//--- hdl/mips_soc.sv
// Core with one APB master; gpio_data_in is sampled only when a lw reads the input offset
`timescale 1ns/100ps

module mips_soc
    import mips_isa_pkg::*;
    import mips_bus_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  gpio_t gpio_data_in,
    output gpio_t gpio_data_out,
    output logic  gpio_strobe
);
    ctrl_t         ctrl;
    instr_fields_t fields;
    logic          zero;
    logic          bus_done;

    apb_if u_core_bus (.pclk(clk));         // Core side of the decoder
    apb_if u_mem_bus  (.pclk(clk));
    apb_if u_gpio_bus (.pclk(clk));

    mips_control u_control (
        .clk      (clk),
        .reset    (reset),
        .fields   (fields),
        .zero     (zero),
        .bus_done (bus_done),
        .ctrl     (ctrl)
    );

    mips_datapath u_datapath (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .fields   (fields),
        .zero     (zero),
        .bus_done (bus_done),
        .bus      (u_core_bus)
    );

    apb_decoder u_decoder (
        .up   (u_core_bus),
        .mem  (u_mem_bus),
        .gpio (u_gpio_bus)
    );

    mips_mem u_mem (
        .clk (clk),
        .bus (u_mem_bus)
    );

    gpio_port u_gpio (
        .clk           (clk),
        .reset         (reset),
        .bus           (u_gpio_bus),
        .gpio_data_in  (gpio_data_in),
        .gpio_data_out (gpio_data_out),
        .gpio_strobe   (gpio_strobe)
    );

endmodule

//--- sim/mips_soc_assert.sv
// Watches only the core side of the decoder and the GPIO strobe; every property is off in reset
`timescale 1ns/100ps

module mips_soc_assert
    import mips_bus_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  psel,
    input logic  penable,
    input logic  pwrite,
    input logic  pready,
    input addr_t paddr,
    input word_t pwdata,
    input logic  gpio_strobe
);
    int fail_count = 0;                     // Assertion failures so far

    property setup_then_access;
        @(posedge clk) disable iff (reset)
            (psel && !penable) |=> (psel && penable);
    endproperty

    property enable_needs_select;
        @(posedge clk) disable iff (reset)
            penable |-> psel;
    endproperty

    // Address, direction and write data frozen until pready closes the transfer
    property transfer_stable;
        @(posedge clk) disable iff (reset)
            (psel && !(penable && pready)) |=>
                ($stable(paddr) && $stable(pwrite) && $stable(pwdata));
    endproperty

    property strobe_one_cycle;
        @(posedge clk) disable iff (reset)
            gpio_strobe |=> !gpio_strobe;
    endproperty

    a_setup_access: assert property (setup_then_access)
        else begin
            fail_count++;
            $error("APB setup cycle not followed by an access cycle");
        end
    a_enable_sel:   assert property (enable_needs_select)
        else begin
            fail_count++;
            $error("APB penable high without psel");
        end
    a_stable:       assert property (transfer_stable)
        else begin
            fail_count++;
            $error("APB address or data changed inside a transfer");
        end
    a_strobe_width: assert property (strobe_one_cycle)
        else begin
            fail_count++;
            $error("GPIO strobe longer than one cycle");
        end

endmodule

//--- sim/tb_mips_soc.sv
// Needs sim/prog.hex loaded from the run directory; inputs change only after each GPIO strobe
`timescale 1ns/100ps

module tb_mips_soc
    import mips_bus_pkg::*;
();
    localparam int          clk_period      = 40;
    localparam int          reset_cycles    = 8;
    localparam int          num_fixed       = 4;
    localparam int          num_random      = 40;
    localparam int          num_tests       = num_fixed + num_random;
    localparam int          max_iter_cycles = 79;       // Program loop with the or taken
    localparam int          max_hold        = 8;        // Must stay below the lw read point
    localparam int          timeout_cycles  =
        (reset_cycles + num_tests * max_iter_cycles) * 3 / 2;
    localparam int unsigned rand_seed       = 32'h6de3_3e99;

    logic  clk;
    logic  reset;
    gpio_t gpio_data_in;
    gpio_t gpio_data_out;
    logic  gpio_strobe;

    gpio_t test_vals [num_tests];
    int    test_idx;                        // Index of the value now on gpio_data_in
    int    last_strobe_idx;                 // -1 until the first strobe
    int    strobe_count;
    int    error_count;
    int    cycle_count;
    logic  seen_edge;

    // Output byte the program should produce for input x
    function automatic gpio_t ref_gpio(gpio_t x);
        logic [8:0] sum;
        gpio_t      masked;
        logic       below;
        sum    = {1'b0, x} + 9'd37;
        masked = sum[7:0] & 8'hf0;          // Carry past bit 7 drops out here
        below  = (x < 8'd100);
        return masked | {7'b0, below};
    endfunction

    task automatic wait_for_strobe();
        do begin
            @(posedge clk);
        end while (!gpio_strobe);
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    mips_soc u_mips_soc (
        .clk           (clk),
        .reset         (reset),
        .gpio_data_in  (gpio_data_in),
        .gpio_data_out (gpio_data_out),
        .gpio_strobe   (gpio_strobe)
    );

    bind mips_soc mips_soc_assert u_soc_assert (
        .clk         (clk),
        .reset       (reset),
        .psel        (u_core_bus.psel),
        .penable     (u_core_bus.penable),
        .pwrite      (u_core_bus.pwrite),
        .pready      (u_core_bus.pready),
        .paddr       (u_core_bus.paddr),
        .pwdata      (u_core_bus.pwdata),
        .gpio_strobe (gpio_strobe)
    );

    initial begin
        int hold;
        reset           = 1'b1;
        gpio_data_in    = '0;
        test_idx        = 0;
        last_strobe_idx = -1;
        strobe_count    = 0;
        error_count     = 0;
        cycle_count     = 0;
        seen_edge       = 1'b0;
        void'($urandom(rand_seed));
        test_vals[0]    = 8'd0;             // Branch not taken, slt sets bit 0
        test_vals[1]    = 8'd99;            // Last value below the compare limit
        test_vals[2]    = 8'd100;           // Branch taken
        test_vals[3]    = 8'd255;           // x + 37 carries past 8 bits
        for (int i = num_fixed; i < num_tests; i++) begin
            test_vals[i] = gpio_t'($urandom);
        end

        @(posedge clk);
        gpio_data_in <= test_vals[0];
        repeat (reset_cycles - 1) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < num_tests; i++) begin
            if (i > 0) begin
                gpio_data_in <= test_vals[i];
                test_idx     <= i;
            end
            wait_for_strobe();
            hold = 1 + int'($urandom % max_hold);   // Input held past its strobe
            repeat (hold) @(posedge clk);
        end

        @(negedge clk);
        if (strobe_count != num_tests) begin
            $display("wrong number of strobes: %0d seen for %0d inputs",
                     strobe_count, num_tests);
            error_count++;
        end
        if (u_mips_soc.u_soc_assert.fail_count != 0) begin
            $display("%0d bus or strobe assertions failed",
                     u_mips_soc.u_soc_assert.fail_count);
            error_count++;
        end
        $display("%0d inputs, %0d strobes, %0d errors", num_tests, strobe_count, error_count);
        if (error_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // Compares each strobe against the reference for the input held before it
    always @(posedge clk) begin
        gpio_t expected;
        logic  ok;
        if (seen_edge) begin
            if (reset && gpio_strobe) begin
                $display("gpio_strobe went high during reset at %0t", $time);
                error_count++;
            end
            if ((last_strobe_idx < 0) && !gpio_strobe && (gpio_data_out != '0)) begin
                $display("mismatch at %0t: gpio_data_out %02h before the first strobe",
                         $time, gpio_data_out);
                error_count++;
            end
            if (gpio_strobe) begin
                expected = ref_gpio(gpio_data_in);
                strobe_count++;
                if (test_idx == last_strobe_idx) begin
                    $display("extra strobe at %0t for input %02h with no input change",
                             $time, gpio_data_in);
                    error_count++;
                end else begin
                    ok = (gpio_data_out == expected);
                    if (!ok) begin
                        $display("mismatch at %0t: input %02h gave %02h, expected %02h",
                                 $time, gpio_data_in, gpio_data_out, expected);
                        error_count++;
                    end
                    $display("test %0d: input %02h output %02h %s", test_idx,
                             gpio_data_in, gpio_data_out, ok ? "ok" : "FAILED");
                    last_strobe_idx = test_idx;
                end
            end
        end
        seen_edge = 1'b1;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout after %0d cycles with %0d of %0d inputs answered",
                     cycle_count, strobe_count, num_tests);
            $display("Done: errors found");
            $finish;
        end
    end

endmodule

//--- sim/prog.hex
// One 32-bit instruction word per line in hex, loaded from byte address 0 upward
// Comment after each word: byte address, then the instruction
8c080804  // 00 lw    $8, 0x804($0)    x from the GPIO input
ac080320  // 04 sw    $8, 0x320($0)    to memory word 200
8c090320  // 08 lw    $9, 0x320($0)    read back
24000005  // 0c addiu $0, $0, 5        must not change $zero
01205021  // 10 addu  $10, $9, $0
240b0025  // 14 addiu $11, $0, 37
014b6021  // 18 addu  $12, $10, $11
318c00f0  // 1c andi  $12, $12, 0xf0
240d0064  // 20 addiu $13, $0, 100
014d702a  // 24 slt   $14, $10, $13
11c00001  // 28 beq   $14, $0, +1      skip the or when x >= 100
018e6025  // 2c or    $12, $12, $14
ac0c0800  // 30 sw    $12, 0x800($0)   GPIO output and strobe
018e0023  // 34 subu  $0, $12, $14     write to $zero is dropped
08000000  // 38 j     0

//--- sources.f
hdl/mips_isa_pkg.sv
hdl/mips_bus_pkg.sv
hdl/apb_if.sv
hdl/mips_control.sv
hdl/mips_datapath.sv
hdl/apb_decoder.sv
hdl/mips_mem.sv
hdl/gpio_port.sv
hdl/mips_soc.sv
sim/mips_soc_assert.sv
sim/tb_mips_soc.sv

//--- Makefile
TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
TOP        := tb_mips_soc
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Done: no errors

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
